//--- common/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;      // Data, address or instruction word
    typedef logic [3:0]  regIndex_t;
    typedef logic [11:0] imm_t;       // Signed immediate field
    typedef logic [3:0]  aluOp_t;     // Taken straight from the instruction

    typedef struct packed {
        logic      immType;          // Set for (X op imm) + Y
        logic      store;
        logic      deref;
        regIndex_t regZ;
        regIndex_t regX;
        regIndex_t regY;
        aluOp_t    op;
        imm_t      imm;
        logic      illegal;
        logic      branch;
    } decodedInsn_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } memRequest_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } cpuPhase_t;

    localparam word_t     RESET_VECTOR   = 32'h0000_0000;
    localparam regIndex_t REG_ZERO       = 4'd0;
    localparam regIndex_t REG_PC         = 4'd15;
    localparam int        DATA_WORDS     = 256;
    localparam int        DATA_ADDR_BITS = $clog2(DATA_WORDS);
    localparam word_t     IO_ADDR        = 32'h0000_1000;

    // ALU codes with 4 and 15 reserved
    localparam aluOp_t OP_OR   = 4'd0;
    localparam aluOp_t OP_AND  = 4'd1;
    localparam aluOp_t OP_ADD  = 4'd2;
    localparam aluOp_t OP_MUL  = 4'd3;
    localparam aluOp_t OP_SHL  = 4'd5;
    localparam aluOp_t OP_LT   = 4'd6;
    localparam aluOp_t OP_EQ   = 4'd7;
    localparam aluOp_t OP_GT   = 4'd8;
    localparam aluOp_t OP_ANDN = 4'd9;
    localparam aluOp_t OP_XOR  = 4'd10;
    localparam aluOp_t OP_SUB  = 4'd11;
    localparam aluOp_t OP_XNOR = 4'd12;
    localparam aluOp_t OP_SHR  = 4'd13;
    localparam aluOp_t OP_NE   = 4'd14;

endpackage

//--- design/core/decoder.sv
`timescale 1ns/1ps

module decoder import cpuPkg::*; (
    input  word_t        insn,
    output decodedInsn_t decoded
);

    // Field positions follow the three-operand format
    assign decoded.immType = insn[30];
    assign decoded.store   = insn[29];
    assign decoded.deref   = insn[28];
    assign decoded.regZ    = insn[27:24];
    assign decoded.regX    = insn[23:20];
    assign decoded.regY    = insn[19:16];
    assign decoded.op      = insn[15:12];
    assign decoded.imm     = insn[11:0];

    // All-ones word is the halt pattern
    assign decoded.illegal = &insn;

    // A register write to the PC is a jump
    assign decoded.branch  = (insn[27:24] == REG_PC) && !insn[29];

endmodule

//--- design/core/regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      writeEnable,
    input  regIndex_t readX,
    input  regIndex_t readY,
    input  regIndex_t readZ,
    input  regIndex_t writeIndex,
    input  word_t     writeData,
    input  word_t     pcValue,
    output word_t     valueX,
    output word_t     valueY,
    output word_t     valueZ
);

    word_t regs [REG_ZERO + 1 : REG_PC - 1];   // Only 1..14 have storage

    function automatic word_t readReg(regIndex_t index, word_t pc);
        if (index == REG_ZERO) begin
            return '0;
        end
        if (index == REG_PC) begin
            return pc + 1;                      // Address of next instruction
        end
        return regs[index];
    endfunction

    always_comb begin
        valueX = readReg(readX, pcValue);
        valueY = readReg(readY, pcValue);
        valueZ = readReg(readZ, pcValue);
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = REG_ZERO + 1; i < REG_PC; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeIndex != REG_ZERO && writeIndex != REG_PC) begin
            regs[writeIndex] <= writeData;
        end
    end

endmodule

//--- design/core/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import cpuPkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         enable,
    input  decodedInsn_t decoded,
    input  word_t        valueX,
    input  word_t        valueY,
    output word_t        result
);

    word_t immExt;
    word_t operandB;
    word_t addend;
    word_t opResult;

    assign immExt   = {{($bits(word_t) - $bits(imm_t)){decoded.imm[11]}}, decoded.imm};
    assign operandB = decoded.immType ? immExt : valueY;   // Second ALU input
    assign addend   = decoded.immType ? valueY : immExt;   // Added after the op

    always_comb begin
        case (decoded.op)
            OP_OR:   opResult = valueX | operandB;
            OP_AND:  opResult = valueX & operandB;
            OP_ADD:  opResult = valueX + operandB;
            OP_MUL:  opResult = valueX * operandB;
            OP_SHL:  opResult = valueX << operandB;
            OP_LT:   opResult = {32{$signed(valueX) < $signed(operandB)}};
            OP_EQ:   opResult = {32{valueX == operandB}};
            OP_GT:   opResult = {32{$signed(valueX) > $signed(operandB)}};
            OP_ANDN: opResult = valueX & ~operandB;
            OP_XOR:  opResult = valueX ^ operandB;
            OP_SUB:  opResult = valueX - operandB;
            OP_XNOR: opResult = valueX ^~ operandB;
            OP_SHR:  opResult = valueX >> operandB;             // Logical shift
            OP_NE:   opResult = {32{valueX != operandB}};
            default: opResult = '0;                             // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result <= '0;
        end else if (enable) begin
            result <= opResult + addend;
        end
    end

endmodule

//--- design/core/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        run,
    output word_t       instrAddr,
    input  word_t       instrData,
    output memRequest_t memRequest,
    input  word_t       loadData,
    output logic        halted
);

    cpuPhase_t    phase;
    word_t        instrReg;
    word_t        currentInsn;
    decodedInsn_t decoded;
    word_t        valueX;
    word_t        valueY;
    word_t        valueZ;
    word_t        result;
    word_t        writeValue;
    logic         regWrite;
    logic         memAccess;

    // Fetched word is decoded live in DECODE so an illegal word halts at once
    assign currentInsn = (phase == DECODE) ? instrData : instrReg;

    assign memAccess  = decoded.store || decoded.deref;
    assign writeValue = decoded.deref ? loadData : result;
    assign regWrite   = run && (phase == WRITEBACK) && !decoded.store;
    assign halted     = (phase == HALTED);

    decoder decode (
        .insn    (currentInsn),
        .decoded (decoded)
    );

    regFile regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .writeEnable (regWrite),
        .readX       (decoded.regX),
        .readY       (decoded.regY),
        .readZ       (decoded.regZ),
        .writeIndex  (decoded.regZ),
        .writeData   (writeValue),
        .pcValue     (instrAddr),
        .valueX      (valueX),
        .valueY      (valueY),
        .valueZ      (valueZ)
    );

    executeUnit exec (
        .clk     (clk),
        .reset_n (reset_n),
        .enable  (run && phase == EXECUTE),
        .decoded (decoded),
        .valueX  (valueX),
        .valueY  (valueY),
        .result  (result)
    );

    // Phase sequencer and program counter
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase     <= FETCH;
            instrAddr <= RESET_VECTOR;
        end else if (run) begin
            case (phase)
                FETCH:     phase <= DECODE;
                DECODE:    phase <= decoded.illegal ? HALTED : EXECUTE;
                EXECUTE:   phase <= MEMORY;
                MEMORY:    phase <= WRITEBACK;
                WRITEBACK: begin
                    instrAddr <= decoded.branch ? writeValue : instrAddr + 1;
                    phase     <= FETCH;
                end
                HALTED:    phase <= HALTED;     // Left only by reset
                default:   phase <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (run && phase == DECODE) begin
            instrReg <= instrData;
        end
    end

    // Store with deref writes Z to [result], without deref writes result to [Z]
    always_comb begin
        memRequest.valid = run && (phase == MEMORY) && memAccess;
        memRequest.write = decoded.store;
        memRequest.addr  = (decoded.store && !decoded.deref) ? valueZ : result;
        memRequest.wdata = decoded.deref ? valueZ : result;
    end

endmodule

//--- design/memoryMap.sv
`timescale 1ns/1ps

module memoryMap import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  memRequest_t request,
    output word_t       loadData,
    output logic        ramEnable,
    output logic        ramWrite,
    output word_t       ramAddr,
    output word_t       ramWriteData,
    input  word_t       ramReadData,
    input  word_t       ioIn,
    output word_t       ioData,
    output logic        ioValid
);

    logic  isRam;
    logic  isIo;
    logic  ioWrite;
    logic  isRead;
    logic  loadFromRam;     // Source of the pending load
    logic  loadFromIo;
    word_t ioSample;

    assign isRam   = request.addr < DATA_WORDS;
    assign isIo    = request.addr == IO_ADDR;
    assign isRead  = request.valid && !request.write;
    assign ioWrite = request.valid && request.write && isIo;

    assign ramEnable    = request.valid && isRam;
    assign ramWrite     = request.valid && request.write && isRam;
    assign ramAddr      = request.addr;
    assign ramWriteData = request.wdata;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ioData      <= '0;
            ioValid     <= 1'b0;
            loadFromRam <= 1'b0;
            loadFromIo  <= 1'b0;
        end else begin
            ioValid <= ioWrite;             // One-cycle strobe
            if (ioWrite) begin
                ioData <= request.wdata;
            end
            if (isRead) begin
                loadFromRam <= isRam;
                loadFromIo  <= isIo;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (isRead && isIo) begin
            ioSample <= ioIn;
        end
    end

    // Unmapped reads fall through to zero
    always_comb begin
        if (loadFromRam) begin
            loadData = ramReadData;
        end else if (loadFromIo) begin
            loadData = ioSample;
        end else begin
            loadData = '0;
        end
    end

endmodule

//--- design/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import cpuPkg::*; (
    input  logic  clk,
    input  logic  enable,
    input  logic  write,
    input  word_t addr,
    input  word_t writeData,
    output word_t readData
);

    word_t mem [DATA_WORDS];
    logic [DATA_ADDR_BITS-1:0] index;

    assign index = addr[DATA_ADDR_BITS-1:0];   // Word address into the array

    always_ff @(posedge clk) begin
        if (enable) begin
            if (write) begin
                mem[index] <= writeData;
            end
            readData <= mem[index];             // Old contents on a write
        end
    end

endmodule

//--- design/cpuSystem.sv
`timescale 1ns/1ps

module cpuSystem import cpuPkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  run,
    output word_t instrAddr,
    input  word_t instrData,
    input  word_t ioIn,
    output word_t ioData,
    output logic  ioValid,
    output logic  halted
);

    memRequest_t memRequest;
    word_t       loadData;
    logic        ramEnable;
    logic        ramWrite;
    word_t       ramAddr;
    word_t       ramWriteData;
    word_t       ramReadData;

    cpuCore core (
        .clk        (clk),
        .reset_n    (reset_n),
        .run        (run),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .memRequest (memRequest),
        .loadData   (loadData),
        .halted     (halted)
    );

    memoryMap map (
        .clk          (clk),
        .reset_n      (reset_n),
        .request      (memRequest),
        .loadData     (loadData),
        .ramEnable    (ramEnable),
        .ramWrite     (ramWrite),
        .ramAddr      (ramAddr),
        .ramWriteData (ramWriteData),
        .ramReadData  (ramReadData),
        .ioIn         (ioIn),
        .ioData       (ioData),
        .ioValid      (ioValid)
    );

    dataMemory ram (
        .clk       (clk),
        .enable    (ramEnable),
        .write     (ramWrite),
        .addr      (ramAddr),
        .writeData (ramWriteData),
        .readData  (ramReadData)
    );

endmodule

//--- tests/cpuSystem_asserts.sv
`timescale 1ns/1ps

module cpuSystem_asserts import cpuPkg::*; (
    input logic      clk,
    input logic      reset_n,
    input logic      halted,
    input logic      ioValid,
    input word_t     instrAddr,
    input cpuPhase_t phase
);

    int failCount = 0;

    // HALTED is left only through reset
    haltSticky: assert property (@(posedge clk) disable iff (!reset_n) halted |=> halted)
        else begin
            failCount++;
            $error("halted dropped without a reset");
        end

    noStrobeWhenHalted: assert property (@(posedge clk) disable iff (!reset_n)
        !(ioValid && halted))
        else begin
            failCount++;
            $error("ioValid strobe while the core is halted");
        end

    // The fetch address may only move at the end of WRITEBACK
    fetchAddrStable: assert property (@(posedge clk) disable iff (!reset_n)
        !$stable(instrAddr) |-> $past(phase) == WRITEBACK)
        else begin
            failCount++;
            $error("instrAddr changed outside the WRITEBACK to FETCH boundary");
        end

endmodule

bind cpuSystem cpuSystem_asserts checks (
    .clk       (clk),
    .reset_n   (reset_n),
    .halted    (halted),
    .ioValid   (ioValid),
    .instrAddr (instrAddr),
    .phase     (core.phase)
);

//--- tests/cpuSystem_tb.sv
`timescale 1ns/1ps

module cpuSystem_tb import cpuPkg::*; ();

    logic   clk = 1'b0;
    logic   reset_n;
    logic   run;
    word_t  instrAddr;
    word_t  instrData;
    word_t  ioIn;
    word_t  ioData;
    logic   ioValid;
    logic   halted;

    word_t  rom [512];          // Instruction ROM model
    int     progLen;
    word_t  expected [$];       // Port values in the order they must appear
    integer seed;
    int     cycleCount = 0;
    int     cycleLimit = 20;

    cpuSystem UUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .run       (run),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .ioIn      (ioIn),
        .ioData    (ioData),
        .ioValid   (ioValid),
        .halted    (halted)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        instrData <= (instrAddr < $size(rom)) ? rom[instrAddr] : '1;   // Past the end halts
    end

    task automatic reportFailure(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        if (got !== exp) begin
            reportFailure($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            reportFailure($sformatf("Timeout after %0d cycles, the core did not halt in time",
                                    cycleCount));
        end
    end

    always @(posedge clk) begin
        if (UUT.checks.failCount != 0) begin
            reportFailure("A bound assertion on the DUT failed");
        end
    end

    // Every port strobe must match the next expected value
    always @(posedge clk) begin
        if (reset_n === 1'b1 && ioValid === 1'b1) begin
            if (expected.size() == 0) begin
                reportFailure($sformatf("Output strobe with value %h that no test expects",
                                        ioData));
            end else begin
                checkWord("ioData", ioData, expected.pop_front());
            end
        end
    end

    function automatic word_t encodeInsn(logic immType, logic store, logic deref, regIndex_t z,
                                         regIndex_t x, regIndex_t y, aluOp_t op, imm_t imm);
        return {1'b0, immType, store, deref, z, x, y, op, imm};
    endfunction

    function automatic word_t signExtend(imm_t imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t opModel(aluOp_t op, word_t a, word_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (op)
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_ADD:  return a + b;
            OP_MUL:  return a * b;
            OP_SHL:  return a << b;
            OP_SHR:  return a >> b;
            OP_LT:   return (sa < sb) ? 32'hFFFF_FFFF : 32'h0;
            OP_EQ:   return (a == b) ? 32'hFFFF_FFFF : 32'h0;
            OP_GT:   return (sa > sb) ? 32'hFFFF_FFFF : 32'h0;
            OP_NE:   return (a != b) ? 32'hFFFF_FFFF : 32'h0;
            OP_ANDN: return a & ~b;
            OP_XOR:  return a ^ b;
            OP_SUB:  return a - b;
            OP_XNOR: return ~(a ^ b);
            default: return 32'h0;      // Codes 4 and 15
        endcase
    endfunction

    task automatic emit(logic immType, logic store, logic deref, regIndex_t z, regIndex_t x,
                        regIndex_t y, aluOp_t op, imm_t imm);
        rom[progLen] = encodeInsn(immType, store, deref, z, x, y, op, imm);
        progLen++;
    endtask

    // Builds a constant a byte at a time with the shift of 8 held in r13
    task automatic loadConst(regIndex_t r, word_t value);
        emit(1'b0, 1'b0, 1'b0, r, 4'd0, 4'd0, OP_OR, {4'h0, value[31:24]});
        for (int i = 2; i >= 0; i--) begin
            emit(1'b0, 1'b0, 1'b0, r, r, 4'd13, OP_SHL, {4'h0, value[i*8 +: 8]});
        end
    endtask

    task automatic sendOut(regIndex_t r, word_t value);
        emit(1'b0, 1'b1, 1'b0, 4'd12, r, 4'd0, OP_OR, 12'd0);    // [r12] = r
        expected.push_back(value);
    endtask

    task automatic beginProgram();
        foreach (rom[i]) begin
            rom[i] = '1;
        end
        progLen = 0;
        expected.delete();
        emit(1'b0, 1'b0, 1'b0, 4'd13, 4'd0, 4'd0, OP_OR, 12'd8);
        loadConst(4'd12, IO_ADDR);
    endtask

    task automatic opCheck(logic immType, aluOp_t op, word_t a, word_t b, imm_t imm);
        loadConst(4'd1, a);
        loadConst(4'd2, b);
        emit(immType, 1'b1, 1'b0, 4'd12, 4'd1, 4'd2, op, imm);
        if (immType) begin
            expected.push_back(opModel(op, a, signExtend(imm)) + b);
        end else begin
            expected.push_back(opModel(op, a, b) + signExtend(imm));
        end
    endtask

    // Resets, runs to halt and checks the halt cycle against five cycles per instruction
    task automatic runProgram(int executed, int stallAt, int stallLen);
        int cycles;
        cycleLimit += executed * 5 + stallLen + 40;
        @(posedge clk);
        reset_n <= 1'b0;
        run     <= 1'b1;
        repeat (8) @(posedge clk);
        checkWord("instrAddr", instrAddr, RESET_VECTOR);
        checkFlag("halted", halted, 1'b0);
        checkFlag("ioValid", ioValid, 1'b0);
        checkWord("ioData", ioData, '0);
        reset_n <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (stallLen > 0 && cycles == stallAt) begin
                run <= 1'b0;
            end
            if (stallLen > 0 && cycles == stallAt + stallLen) begin
                run <= 1'b1;
            end
        end while (!halted);
        checkWord("haltCycle", word_t'(cycles), word_t'(executed * 5 + 3 + stallLen));
        if (expected.size() != 0) begin
            reportFailure($sformatf("Core halted with %0d expected outputs never seen",
                                    expected.size()));
        end
        repeat (4) begin
            @(posedge clk);
            checkFlag("halted", halted, 1'b1);
            checkFlag("ioValid", ioValid, 1'b0);
        end
    endtask

    task automatic testAluRegister();
        word_t a;
        word_t b;
        beginProgram();
        for (int op = 0; op < 16; op++) begin
            a = $random(seed);
            b = $random(seed);
            if (aluOp_t'(op) == OP_SHL || aluOp_t'(op) == OP_SHR) begin
                b[31:5] = '0;
            end
            opCheck(1'b0, aluOp_t'(op), a, b, imm_t'($random(seed)));
        end
        emit(1'b0, 1'b1, 1'b0, 4'd12, 4'd1, 4'd1, OP_EQ, 12'd0);  // r1 against itself
        expected.push_back(opModel(OP_EQ, a, a));
        emit(1'b0, 1'b1, 1'b0, 4'd12, 4'd1, 4'd1, OP_NE, 12'd0);
        expected.push_back(opModel(OP_NE, a, a));
        runProgram(progLen, 0, 0);
    endtask

    task automatic testAluImmediate();
        word_t a;
        word_t b;
        word_t r;
        imm_t  imm;
        beginProgram();
        for (int op = 0; op < 16; op++) begin
            a = $random(seed);
            b = $random(seed);
            r = $random(seed);
            if (aluOp_t'(op) == OP_SHL || aluOp_t'(op) == OP_SHR) begin
                imm = {7'd0, r[4:0]};
            end else begin
                imm = {1'b1, r[10:0]};      // Negative immediate
            end
            opCheck(1'b1, aluOp_t'(op), a, b, imm);
        end
        runProgram(progLen, 0, 0);
    endtask

    task automatic testRamRoundTrip();
        word_t v1;
        word_t v2;
        v1 = $random(seed);
        v2 = $random(seed);
        beginProgram();
        loadConst(4'd1, v1);
        loadConst(4'd2, v2);
        emit(1'b0, 1'b0, 1'b0, 4'd3, 4'd0, 4'd0, OP_OR, 12'd17);
        emit(1'b0, 1'b0, 1'b0, 4'd4, 4'd0, 4'd0, OP_OR, 12'd200);
        emit(1'b0, 1'b1, 1'b0, 4'd3, 4'd1, 4'd0, OP_OR, 12'd0);   // [r3] = r1
        emit(1'b0, 1'b1, 1'b1, 4'd2, 4'd4, 4'd0, OP_OR, 12'd0);   // [r4] = r2
        emit(1'b0, 1'b1, 1'b1, 4'd1, 4'd0, 4'd0, OP_OR, 12'd55);  // [55] = r1
        loadConst(4'd10, 32'd273);
        emit(1'b0, 1'b1, 1'b0, 4'd10, 4'd2, 4'd0, OP_OR, 12'd0);  // Unmapped store is dropped
        emit(1'b0, 1'b0, 1'b1, 4'd5, 4'd3, 4'd0, OP_OR, 12'd0);
        sendOut(4'd5, v1);
        emit(1'b0, 1'b0, 1'b1, 4'd6, 4'd0, 4'd0, OP_OR, 12'd200);
        sendOut(4'd6, v2);
        emit(1'b0, 1'b0, 1'b1, 4'd7, 4'd3, 4'd0, OP_OR, 12'd38);  // 17 + 38
        sendOut(4'd7, v1);
        loadConst(4'd8, v2);
        loadConst(4'd9, 32'h0000_2000);
        emit(1'b0, 1'b0, 1'b1, 4'd8, 4'd9, 4'd0, OP_OR, 12'd0);
        sendOut(4'd8, 32'h0);
        runProgram(progLen, 0, 0);
    endtask

    task automatic testControlFlow();
        word_t r;
        int    count;
        int    pcAt;
        r = $random(seed);
        count = 5 + int'(r[2:0]);
        beginProgram();
        emit(1'b0, 1'b0, 1'b0, 4'd15, 4'd15, 4'd0, OP_OR, 12'd1);   // Jump over one word
        emit(1'b0, 1'b1, 1'b0, 4'd12, 4'd0, 4'd0, OP_OR, 12'h0AD);
        emit(1'b0, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, OP_OR, 12'd123);
        sendOut(4'd0, 32'h0);
        pcAt = progLen;
        sendOut(4'd15, word_t'(pcAt + 1));
        loadConst(4'd2, word_t'(count));
        emit(1'b0, 1'b0, 1'b0, 4'd1, 4'd0, 4'd0, OP_OR, 12'd0);
        emit(1'b1, 1'b0, 1'b0, 4'd1, 4'd1, 4'd0, OP_ADD, 12'd1);    // Loop head
        emit(1'b0, 1'b0, 1'b0, 4'd4, 4'd1, 4'd2, OP_NE, 12'd0);
        emit(1'b1, 1'b0, 1'b0, 4'd15, 4'd4, 4'd15, OP_AND, 12'hFFD); // Back 3 when r4 set
        sendOut(4'd1, word_t'(count));
        runProgram(progLen - 1 + 3 * (count - 1), 0, 0);
    endtask

    task automatic testInputPort();
        word_t value;
        value = $random(seed);
        beginProgram();
        loadConst(4'd1, ~value);
        sendOut(4'd1, ~value);
        emit(1'b0, 1'b0, 1'b1, 4'd3, 4'd12, 4'd0, OP_OR, 12'd0);   // r3 = [IO_ADDR]
        sendOut(4'd3, value);
        @(posedge clk);
        ioIn <= value;
        runProgram(progLen, 0, 0);
    endtask

    task automatic buildHaltProgram(word_t a, word_t b, output int haltAt, output int storeAt);
        beginProgram();
        opCheck(1'b0, OP_SUB, a, b, 12'd5);
        storeAt = progLen - 1;
        opCheck(1'b1, OP_XNOR, a, b, 12'hF00);
        haltAt = progLen;
        rom[progLen] = '1;
        progLen++;
        emit(1'b0, 1'b1, 1'b0, 4'd12, 4'd1, 4'd0, OP_OR, 12'd0);   // Never reached
    endtask

    task automatic testHaltAndRun();
        word_t a;
        word_t b;
        int    haltAt;
        int    storeAt;
        a = $random(seed);
        b = $random(seed);
        buildHaltProgram(a, b, haltAt, storeAt);
        runProgram(haltAt, 0, 0);
        buildHaltProgram(a, b, haltAt, storeAt);
        runProgram(haltAt, storeAt * 5 + 3, 9);     // Frozen through MEMORY of the first store
    endtask

    initial begin
        seed = 32'h658b6f03;
        reset_n   <= 1'b0;
        run       <= 1'b0;
        ioIn      <= '0;
        instrData <= '1;
        testAluRegister();
        testAluImmediate();
        testRamRoundTrip();
        testControlFlow();
        testInputPort();
        testHaltAndRun();
        @(negedge clk);
        if (UUT.checks.failCount != 0) begin
            reportFailure("A bound assertion on the DUT failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- list.f
common/cpuPkg.sv
design/core/decoder.sv
design/core/regFile.sv
design/core/executeUnit.sv
design/core/cpuCore.sv
design/memoryMap.sv
design/dataMemory.sv
design/cpuSystem.sv
tests/cpuSystem_asserts.sv
tests/cpuSystem_tb.sv

//--- Bender.yml
package:
  name: cpuSystem

sources:
  - files:
      - common/cpuPkg.sv
      - design/core/decoder.sv
      - design/core/regFile.sv
      - design/core/executeUnit.sv
      - design/core/cpuCore.sv
      - design/memoryMap.sv
      - design/dataMemory.sv
      - design/cpuSystem.sv
  - target: test
    files:
      - tests/cpuSystem_asserts.sv
      - tests/cpuSystem_tb.sv
